// ==== include/dmac_params.svh ====
/* dmac parameters
   widths, queue depth and register map of the DMA wrapper */

`ifndef DMAC_PARAMS_SVH
`define DMAC_PARAMS_SVH

// datapath and counter widths
`define DMAC_ADDR_WIDTH     16
`define DMAC_DATA_WIDTH     32
`define DMAC_LEN_WIDTH      16
`define DMAC_REPS_WIDTH     8
`define DMAC_ID_WIDTH       32
`define DMAC_QUEUE_DEPTH    2
`define DMAC_REG_ADDR_WIDTH 4

// register map, word offsets
`define DMAC_REG_SRC        4'd0
`define DMAC_REG_DST        4'd1
`define DMAC_REG_LEN        4'd2
`define DMAC_REG_REPS       4'd3
`define DMAC_REG_SRC_STRIDE 4'd4
`define DMAC_REG_DST_STRIDE 4'd5
`define DMAC_REG_LAUNCH     4'd6
`define DMAC_REG_DONE_ID    4'd7
`define DMAC_REG_STATUS     4'd8

`endif

// ==== source/dmac_pkg.sv ====
/* dmac package
   scalar types and packed structs shared by the DMA wrapper blocks */

`include "dmac_params.svh"

package dmac_pkg;

  // --------------------------------------------------
  // scalar types
  // --------------------------------------------------
  typedef logic [`DMAC_ADDR_WIDTH-1:0]     addr_t;
  typedef logic [`DMAC_DATA_WIDTH-1:0]     data_t;
  typedef logic [`DMAC_LEN_WIDTH-1:0]      len_t;
  typedef logic [`DMAC_REPS_WIDTH-1:0]     reps_t;
  typedef logic [`DMAC_ID_WIDTH-1:0]       id_t;
  typedef logic [`DMAC_REG_ADDR_WIDTH-1:0] reg_addr_t;

  // --------------------------------------------------
  // bundles
  // --------------------------------------------------

  // one access on the register port
  typedef struct packed {
    logic      wr;
    reg_addr_t addr;
    data_t     wdata;
  } reg_req_t;

  // one 2D transfer, rows of len words repeated reps times
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
    reps_t reps;
    addr_t src_stride;
    addr_t dst_stride;
  } nd_req_t;

  // one word access on the memory port
  typedef struct packed {
    logic  wr;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

endpackage

// ==== source/dmac_reg_frontend.sv ====
/* dmac register frontend
   config registers, launch into the request queue, transfer ID counters */

`timescale 1ns/1ps

`include "dmac_params.svh"

module dmac_reg_frontend (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               reg_valid_i,
  input  dmac_pkg::reg_req_t reg_req_i,
  input  logic               push_ready_i,
  input  logic               done_i,
  input  logic               busy_i,
  output logic               reg_gnt_o,
  output logic               reg_rvalid_o,
  output dmac_pkg::data_t    reg_rdata_o,
  output logic               push_valid_o,
  output dmac_pkg::nd_req_t  nd_req_o
);

  import dmac_pkg::*;

  nd_req_t cfg_q;
  id_t     next_id_q;
  id_t     done_id_q;
  data_t   rdata_d;
  logic    launch_rd;
  logic    access;
  logic    push;

  // --------------------------------------------------
  // access decode
  // --------------------------------------------------

  // a launch is a read of the launch register
  assign launch_rd = reg_valid_i && !reg_req_i.wr && (reg_req_i.addr == `DMAC_REG_LAUNCH);

  // only back-pressure: launch while the queue is full
  assign reg_gnt_o = !(launch_rd && !push_ready_i);
  assign access    = reg_valid_i && reg_gnt_o;

  assign push_valid_o = launch_rd;
  assign push         = push_valid_o && push_ready_i;
  assign nd_req_o     = cfg_q;

  // config write port
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q <= '0;
    end else if (access && reg_req_i.wr) begin
      case (reg_req_i.addr)
        `DMAC_REG_SRC:        cfg_q.src        <= addr_t'(reg_req_i.wdata);
        `DMAC_REG_DST:        cfg_q.dst        <= addr_t'(reg_req_i.wdata);
        `DMAC_REG_LEN:        cfg_q.len        <= len_t'(reg_req_i.wdata);
        `DMAC_REG_REPS:       cfg_q.reps       <= reps_t'(reg_req_i.wdata);
        `DMAC_REG_SRC_STRIDE: cfg_q.src_stride <= addr_t'(reg_req_i.wdata);
        `DMAC_REG_DST_STRIDE: cfg_q.dst_stride <= addr_t'(reg_req_i.wdata);
        default: ;
      endcase
    end
  end

  // --------------------------------------------------
  // read data
  // --------------------------------------------------
  always_comb begin
    rdata_d = '0;
    case (reg_req_i.addr)
      `DMAC_REG_SRC:        rdata_d = data_t'(cfg_q.src);
      `DMAC_REG_DST:        rdata_d = data_t'(cfg_q.dst);
      `DMAC_REG_LEN:        rdata_d = data_t'(cfg_q.len);
      `DMAC_REG_REPS:       rdata_d = data_t'(cfg_q.reps);
      `DMAC_REG_SRC_STRIDE: rdata_d = data_t'(cfg_q.src_stride);
      `DMAC_REG_DST_STRIDE: rdata_d = data_t'(cfg_q.dst_stride);
      // launch returns the ID handed to this transfer
      `DMAC_REG_LAUNCH:     rdata_d = data_t'(next_id_q);
      `DMAC_REG_DONE_ID:    rdata_d = data_t'(done_id_q);
      `DMAC_REG_STATUS:     rdata_d = data_t'(busy_i);
      default:              rdata_d = '0;
    endcase
  end

  // response one cycle after the grant, writes included
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_rvalid_o <= 1'b0;
    end else begin
      reg_rvalid_o <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      reg_rdata_o <= reg_req_i.wr ? '0 : rdata_d;
    end
  end

  // --------------------------------------------------
  // transfer ID counters
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      next_id_q <= id_t'(1);
      done_id_q <= '0;
    end else begin
      if (push) begin
        next_id_q <= next_id_q + id_t'(1);
      end
      if (done_i) begin
        done_id_q <= done_id_q + id_t'(1);
      end
    end
  end

  // every completion belongs to a launched transfer
  a_done_after_launch : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    done_i |-> ((done_id_q + id_t'(1)) != next_id_q)
  );

endmodule

// ==== source/dmac_req_fifo.sv ====
/* dmac request fifo
   circular buffer for any payload type, pop visible the cycle after push */

`timescale 1ns/1ps

`include "dmac_params.svh"

module dmac_req_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = `DMAC_QUEUE_DEPTH
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic push_valid_i,
  input  T     data_i,
  input  logic pop_ready_i,
  output logic push_ready_o,
  output logic pop_valid_o,
  output T     data_o,
  output logic empty_o
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  T                  mem_q [DEPTH];
  logic [PtrW-1:0]   wr_ptr_q;
  logic [PtrW-1:0]   rd_ptr_q;
  logic [CntW-1:0]   count_q;
  logic              push;
  logic              pop;

  assign push_ready_o = (count_q != CntW'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign empty_o      = (count_q == '0);
  assign data_o       = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  // pointers wrap at DEPTH, count tracks occupancy
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // occupancy never passes DEPTH, a full queue has the write pointer on the read slot
  a_no_overflow : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (count_q >= CntW'(DEPTH)) |-> (count_q == CntW'(DEPTH) && wr_ptr_q == rd_ptr_q)
  );

  // an empty queue has both pointers on the same slot
  a_no_underflow : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (count_q == '0) |-> (wr_ptr_q == rd_ptr_q)
  );

endmodule

// ==== source/dmac_nd_engine.sv ====
/* dmac nd engine
   walks a 2D request row by row, copying one word per read and write */

`timescale 1ns/1ps

`include "dmac_params.svh"

module dmac_nd_engine (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                req_valid_i,
  input  dmac_pkg::nd_req_t   req_i,
  input  logic                mem_gnt_i,
  input  logic                mem_rvalid_i,
  input  dmac_pkg::data_t     mem_rdata_i,
  output logic                req_ready_o,
  output logic                mem_valid_o,
  output dmac_pkg::mem_req_t  mem_req_o,
  output logic                done_o,
  output logic                busy_o
);

  import dmac_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_wait,
    st_write
  } state_e;

  state_e  state_q;
  nd_req_t req_q;
  addr_t   src_row_q;
  addr_t   dst_row_q;
  len_t    word_cnt_q;
  reps_t   row_cnt_q;
  data_t   rdata_q;
  logic    done_q;
  logic    pop;
  logic    empty_req;
  logic    last_word;
  logic    last_row;

  assign req_ready_o = (state_q == st_idle);
  assign pop         = req_valid_i && req_ready_o;
  assign empty_req   = (req_i.len == '0) || (req_i.reps == '0);

  assign last_word = (word_cnt_q == req_q.len - len_t'(1));
  assign last_row  = (row_cnt_q == req_q.reps - reps_t'(1));

  // done covers its own cycle so status never shows idle before the count moves
  assign done_o = done_q;
  assign busy_o = (state_q != st_idle) || done_q;

  // --------------------------------------------------
  // memory port
  // --------------------------------------------------
  always_comb begin
    mem_valid_o     = 1'b0;
    mem_req_o.wr    = 1'b0;
    mem_req_o.addr  = src_row_q + addr_t'(word_cnt_q);
    mem_req_o.wdata = '0;
    case (state_q)
      st_read: begin
        mem_valid_o = 1'b1;
      end
      st_write: begin
        mem_valid_o     = 1'b1;
        mem_req_o.wr    = 1'b1;
        mem_req_o.addr  = dst_row_q + addr_t'(word_cnt_q);
        mem_req_o.wdata = rdata_q;
      end
      default: ;
    endcase
  end

  // --------------------------------------------------
  // FSM and counters
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= st_idle;
      word_cnt_q <= '0;
      row_cnt_q  <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (pop) begin
            word_cnt_q <= '0;
            row_cnt_q  <= '0;
            // empty transfers retire without touching memory
            if (empty_req) begin
              done_q <= 1'b1;
            end else begin
              state_q <= st_read;
            end
          end
        end
        st_read: begin
          if (mem_gnt_i) begin
            state_q <= st_wait;
          end
        end
        st_wait: begin
          if (mem_rvalid_i) begin
            state_q <= st_write;
          end
        end
        st_write: begin
          if (mem_gnt_i) begin
            if (!last_word) begin
              word_cnt_q <= word_cnt_q + len_t'(1);
              state_q    <= st_read;
            end else if (!last_row) begin
              word_cnt_q <= '0;
              row_cnt_q  <= row_cnt_q + reps_t'(1);
              state_q    <= st_read;
            end else begin
              state_q <= st_idle;
              done_q  <= 1'b1;
            end
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // request, row bases and read data
  always_ff @(posedge clk_i) begin
    if (pop) begin
      req_q     <= req_i;
      src_row_q <= req_i.src;
      dst_row_q <= req_i.dst;
    end else if (state_q == st_write && mem_gnt_i && last_word) begin
      src_row_q <= src_row_q + req_q.src_stride;
      dst_row_q <= dst_row_q + req_q.dst_stride;
    end
    if (state_q == st_wait && mem_rvalid_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  // request held steady until the memory grants it
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (mem_valid_o && !mem_gnt_i) |=> (mem_valid_o && $stable(mem_req_o))
  );

endmodule

// ==== source/dmac_wrap.sv ====
/* dmac wrapper
   register frontend feeding a request queue drained by the 2D copy engine */

`timescale 1ns/1ps

`include "dmac_params.svh"

module dmac_wrap (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               reg_valid_i,
  input  dmac_pkg::reg_req_t reg_req_i,
  input  logic               mem_gnt_i,
  input  logic               mem_rvalid_i,
  input  dmac_pkg::data_t    mem_rdata_i,
  output logic               reg_gnt_o,
  output logic               reg_rvalid_o,
  output dmac_pkg::data_t    reg_rdata_o,
  output logic               mem_valid_o,
  output dmac_pkg::mem_req_t mem_req_o,
  output logic               term_event_o,
  output logic               busy_o
);

  import dmac_pkg::*;

  nd_req_t fe_req;
  nd_req_t queue_req;
  logic    push_valid;
  logic    push_ready;
  logic    pop_valid;
  logic    pop_ready;
  logic    queue_empty;
  logic    engine_busy;
  logic    done;

  // busy while anything is queued or executing
  assign busy_o       = engine_busy | ~queue_empty;
  assign term_event_o = done;

  // --------------------------------------------------
  // frontend
  // --------------------------------------------------
  dmac_reg_frontend i_dmac_reg_frontend (
    .clk_i,
    .arst_n_i,
    .reg_valid_i,
    .reg_req_i,
    .push_ready_i(push_ready),
    .done_i      (done),
    .busy_i      (busy_o),
    .reg_gnt_o,
    .reg_rvalid_o,
    .reg_rdata_o,
    .push_valid_o(push_valid),
    .nd_req_o    (fe_req)
  );

  // --------------------------------------------------
  // request queue
  // --------------------------------------------------
  dmac_req_fifo #(
    .T    (nd_req_t),
    .DEPTH(`DMAC_QUEUE_DEPTH)
  ) i_dmac_req_fifo (
    .clk_i,
    .arst_n_i,
    .push_valid_i(push_valid),
    .data_i      (fe_req),
    .pop_ready_i (pop_ready),
    .push_ready_o(push_ready),
    .pop_valid_o (pop_valid),
    .data_o      (queue_req),
    .empty_o     (queue_empty)
  );

  // --------------------------------------------------
  // 2D engine
  // --------------------------------------------------
  dmac_nd_engine i_dmac_nd_engine (
    .clk_i,
    .arst_n_i,
    .req_valid_i (pop_valid),
    .req_i       (queue_req),
    .mem_gnt_i,
    .mem_rvalid_i,
    .mem_rdata_i,
    .req_ready_o (pop_ready),
    .mem_valid_o,
    .mem_req_o,
    .done_o      (done),
    .busy_o      (engine_busy)
  );

endmodule

// ==== tests/tb_dmac_wrap.sv ====
/* dmac wrapper testbench
   random register and memory traffic checked against a transfer model */

`timescale 1ns/1ps

`include "dmac_params.svh"

module tb_dmac_wrap;

  import dmac_pkg::*;

  // 13 transfers of at most 32 words, under 10 cycles per word with grant stalls,
  // plus register traffic, well inside this limit
  localparam int unsigned timeout_cycles = 20000;

  logic     clk;
  logic     arst_n;
  logic     reg_valid;
  reg_req_t reg_req;
  logic     mem_gnt;
  logic     mem_rvalid;
  data_t    mem_rdata;
  logic     reg_gnt;
  logic     reg_rvalid;
  data_t    reg_rdata;
  logic     mem_valid;
  mem_req_t mem_req;
  logic     term_event;
  logic     busy;

  integer      seed = 32'hd684_54df;
  integer      gnt_seed = 32'hd684_54df;
  string       test_name = "reset";
  data_t       mem_model [1024];
  data_t       ref_mem [1024];
  mem_req_t    exp_wr [$];
  id_t         next_id = id_t'(1);
  id_t         term_count = '0;
  int unsigned cycle_count = 0;
  int unsigned last_stalls = 0;

  dmac_wrap i_dmac_wrap (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .reg_valid_i (reg_valid),
    .reg_req_i   (reg_req),
    .mem_gnt_i   (mem_gnt),
    .mem_rvalid_i(mem_rvalid),
    .mem_rdata_i (mem_rdata),
    .reg_gnt_o   (reg_gnt),
    .reg_rvalid_o(reg_rvalid),
    .reg_rdata_o (reg_rdata),
    .mem_valid_o (mem_valid),
    .mem_req_o   (mem_req),
    .term_event_o(term_event),
    .busy_o      (busy)
  );

  always #20 clk = ~clk;

  // --------------------------------------------------
  // error handling and checks
  // --------------------------------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_reg(input data_t exp, input data_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Error: %s expected %h actual %h", test_name, exp, act));
    end
  endtask

  task automatic check_mem(input mem_req_t exp, input mem_req_t act);
    if (act !== exp) begin
      stop_on_error({$sformatf("Error: %s expected wr=%0b addr=%h data=%h",
                               test_name, exp.wr, exp.addr, exp.wdata),
                     $sformatf(" actual wr=%0b addr=%h data=%h",
                               act.wr, act.addr, act.wdata)});
    end
  endtask

  task automatic check_id(input id_t exp, input id_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Error: %s expected %0d actual %0d", test_name, exp, act));
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles) begin
      stop_on_error($sformatf("timeout after %0d cycles in %s", cycle_count, test_name));
    end
  end

  // done pulses seen on the top level
  always @(negedge clk) begin
    if (arst_n && term_event) begin
      term_count <= term_count + id_t'(1);
    end
  end

  function automatic int unsigned rand_range(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // --------------------------------------------------
  // memory model, random grant and one-cycle read data
  // --------------------------------------------------
  initial begin : memory_model
    mem_req_t req;
    logic     fire;
    forever begin
      @(negedge clk);
      fire = mem_valid && mem_gnt;
      req  = mem_req;
      @(posedge clk);
      #2;
      mem_rvalid = 1'b0;
      if (fire && req.wr) begin
        if (exp_wr.size() == 0) begin
          stop_on_error($sformatf("unexpected memory write to %h in %s", req.addr, test_name));
        end else begin
          check_mem(exp_wr.pop_front(), req);
        end
        mem_model[req.addr[9:0]] = req.wdata;
      end else if (fire) begin
        mem_rvalid = 1'b1;
        mem_rdata  = mem_model[req.addr[9:0]];
      end
      mem_gnt = ($random(gnt_seed) % 2) != 0;
    end
  end

  // expected effect of one transfer, rows in order and words in order
  function automatic void model_transfer(input nd_req_t t);
    mem_req_t w;
    addr_t    s;
    addr_t    d;
    for (int r = 0; r < int'(t.reps); r++) begin
      for (int c = 0; c < int'(t.len); c++) begin
        s = t.src + addr_t'(r) * t.src_stride + addr_t'(c);
        d = t.dst + addr_t'(r) * t.dst_stride + addr_t'(c);
        ref_mem[d[9:0]] = ref_mem[s[9:0]];
        w.wr    = 1'b1;
        w.addr  = d;
        w.wdata = ref_mem[d[9:0]];
        exp_wr.push_back(w);
      end
    end
  endfunction

  // readable bits of each config register
  function automatic data_t field_mask(input int a);
    int w;
    case (a)
      `DMAC_REG_LEN:  w = `DMAC_LEN_WIDTH;
      `DMAC_REG_REPS: w = `DMAC_REPS_WIDTH;
      default:        w = `DMAC_ADDR_WIDTH;
    endcase
    return (data_t'(1) << w) - data_t'(1);
  endfunction

  // --------------------------------------------------
  // register port
  // --------------------------------------------------
  task automatic reg_access(input logic wr, input reg_addr_t addr, input data_t wdata,
                            output data_t rdata);
    logic granted;
    granted       = 1'b0;
    last_stalls   = 0;
    reg_req.wr    = wr;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    reg_valid     = 1'b1;
    while (!granted) begin
      @(negedge clk);
      granted = reg_gnt;
      if (!granted) begin
        last_stalls++;
      end
      @(posedge clk);
      #2;
    end
    reg_valid = 1'b0;
    @(negedge clk);
    if (!reg_rvalid) begin
      stop_on_error($sformatf("no register response after grant in %s", test_name));
    end
    rdata = reg_rdata;
    @(posedge clk);
    #2;
  endtask

  task automatic reg_write(input reg_addr_t addr, input data_t wdata);
    data_t unused;
    reg_access(1'b1, addr, wdata, unused);
  endtask

  task automatic reg_read(input reg_addr_t addr, output data_t rdata);
    reg_access(1'b0, addr, '0, rdata);
  endtask

  task automatic launch(input nd_req_t t);
    data_t rdata;
    reg_write(`DMAC_REG_SRC, data_t'(t.src));
    reg_write(`DMAC_REG_DST, data_t'(t.dst));
    reg_write(`DMAC_REG_LEN, data_t'(t.len));
    reg_write(`DMAC_REG_REPS, data_t'(t.reps));
    reg_write(`DMAC_REG_SRC_STRIDE, data_t'(t.src_stride));
    reg_write(`DMAC_REG_DST_STRIDE, data_t'(t.dst_stride));
    reg_read(`DMAC_REG_LAUNCH, rdata);
    check_id(next_id, id_t'(rdata));
    next_id = next_id + id_t'(1);
    model_transfer(t);
  endtask

  // poll the done count, then expect an idle status
  task automatic wait_done();
    data_t rdata;
    id_t   launched;
    launched = next_id - id_t'(1);
    reg_read(`DMAC_REG_DONE_ID, rdata);
    while (id_t'(rdata) < launched) begin
      reg_read(`DMAC_REG_DONE_ID, rdata);
    end
    check_id(launched, id_t'(rdata));
    check_id(launched, term_count);
    reg_read(`DMAC_REG_STATUS, rdata);
    check_reg('0, rdata);
  endtask

  task automatic expect_busy();
    data_t rdata;
    reg_read(`DMAC_REG_STATUS, rdata);
    check_reg(data_t'(1), rdata);
  endtask

  task automatic compare_memory();
    for (int i = 0; i < 1024; i++) begin
      if (mem_model[i] !== ref_mem[i]) begin
        test_name = $sformatf("memory word %0d", i);
        check_reg(ref_mem[i], mem_model[i]);
      end
    end
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin : stimulus
    data_t   rdata;
    data_t   v;
    nd_req_t t;
    id_t     done_before;
    clk        = 1'b0;
    arst_n     = 1'b0;
    reg_valid  = 1'b0;
    reg_req    = '0;
    mem_gnt    = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    for (int i = 0; i < 1024; i++) begin
      mem_model[i] = data_t'(i) * 32'h9e37_79b9 + 32'h0000_1234;
      ref_mem[i]   = mem_model[i];
    end
    repeat (3) @(posedge clk);
    #2;
    arst_n = 1'b1;
    @(negedge clk);
    if (reg_rvalid || mem_valid || term_event || busy) begin
      stop_on_error("outputs not idle after reset");
    end
    @(posedge clk);
    #2;

    test_name = "config readback";
    for (int a = 0; a < 6; a++) begin
      v = $random(seed);
      reg_write(reg_addr_t'(a), v);
      reg_read(reg_addr_t'(a), rdata);
      check_reg(v & field_mask(a), rdata);
    end
    for (int a = 9; a < 16; a++) begin
      reg_write(reg_addr_t'(a), $random(seed));
      reg_read(reg_addr_t'(a), rdata);
      check_reg('0, rdata);
    end

    test_name        = "1d transfer";
    t.src            = addr_t'(rand_range(256));
    t.dst            = addr_t'(512 + rand_range(256));
    t.len            = len_t'(1 + rand_range(16));
    t.reps           = reps_t'(1);
    t.src_stride     = addr_t'(t.len);
    t.dst_stride     = addr_t'(t.len);
    launch(t);
    expect_busy();
    wait_done();

    test_name = "2d transfers";
    for (int n = 0; n < 6; n++) begin
      t.src        = addr_t'(rand_range(256));
      t.dst        = addr_t'(512 + rand_range(256));
      t.len        = len_t'(1 + rand_range(8));
      t.reps       = reps_t'(1 + rand_range(4));
      t.src_stride = addr_t'(t.len) + addr_t'(rand_range(9));
      t.dst_stride = addr_t'(t.len) + addr_t'(rand_range(9));
      launch(t);
      expect_busy();
    end
    wait_done();
    compare_memory();

    // four long transfers, the last launch finds the queue full
    test_name   = "queue full";
    done_before = term_count;
    for (int n = 0; n < 4; n++) begin
      t.src        = addr_t'(n * 64);
      t.dst        = addr_t'(520 + n * 64);
      t.len        = len_t'(8);
      t.reps       = reps_t'(4);
      t.src_stride = addr_t'(8);
      t.dst_stride = addr_t'(8);
      launch(t);
    end
    if (last_stalls == 0) begin
      stop_on_error("launch into a full request queue was granted at once");
    end
    if (term_count == done_before) begin
      stop_on_error("launch into a full queue was granted before any transfer completed");
    end
    wait_done();

    test_name = "empty transfers";
    t.len     = len_t'(0);
    t.reps    = reps_t'(3);
    launch(t);
    t.len     = len_t'(4);
    t.reps    = reps_t'(0);
    launch(t);
    wait_done();

    test_name = "final memory";
    if (exp_wr.size() != 0) begin
      stop_on_error($sformatf("%0d expected memory writes never happened", exp_wr.size()));
    end
    compare_memory();
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
source/dmac_pkg.sv
source/dmac_reg_frontend.sv
source/dmac_req_fifo.sv
source/dmac_nd_engine.sv
source/dmac_wrap.sv
tests/tb_dmac_wrap.sv

// ==== Makefile ====
# Verilator lint and simulation of the DMA wrapper

TOOL      ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP       ?= tb_dmac_wrap
RTL_TOP   ?= dmac_wrap
FILELIST  ?= sources.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o V$(TOP)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
